/* rs_subsys.f */
source/core_cfg_pkg.sv
source/expipe_pkg.sv
source/prio_enc.sv
source/generic_rs.sv
source/int_eu.sv
source/rs_subsys_top.sv
verification/tb_rs_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Compile the integer issue path with its testbench and run it
# The simulator exit status tells pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_rs_subsys \
    -f rs_subsys.f \
    -o tb_rs_subsys
./obj_dir/tb_rs_subsys

/* source/core_cfg_pkg.sv */
// Core-wide data and ROB tag widths, with the data word and ROB tag vector types
`default_nettype none

package core_cfg_pkg;

    // Integer operand width
    localparam int XLEN = 32;

    // ROB tag width, sets how many results can be in flight
    localparam int ROB_IDX_LEN = 4;

    // One data word on any operand or result path
    typedef logic [XLEN-1:0] xlen_t;

    // Names the ROB entry that produces a value
    // Also used as the CDB tag
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

endpackage

`default_nettype wire

/* source/expipe_pkg.sv */
// Execution pipe operation codes and exception codes
`default_nettype none

package expipe_pkg;

    // Operations handled by the integer execution unit
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        // Iterative, one bit per cycle
        OP_SLL = 2'd3
    } eu_op_e;

    // Exception codes carried from the EU to the CDB
    typedef enum logic [1:0] {
        EXC_NONE      = 2'd0,
        // Signed overflow on add or sub
        EXC_OVERFLOW  = 2'd1,
        // Shift amount of XLEN or more
        EXC_BAD_SHAMT = 2'd2
    } except_e;

endpackage

`default_nettype wire

/* source/generic_rs.sv */
// Reservation station with issue insert, CDB wakeup, EU dispatch, result write-back, CDB release
`timescale 1ns/1ns
`default_nettype none

module generic_rs
    import core_cfg_pkg::*, expipe_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Issue side
    input  logic                        arbiter_valid_i,
    output logic                        arbiter_ready_o,
    input  eu_op_e                      eu_ctl_i,
    input  logic                        rs1_ready_i,
    input  rob_idx_t                    rs1_idx_i,
    input  xlen_t                       rs1_value_i,
    input  logic                        rs2_ready_i,
    input  rob_idx_t                    rs2_idx_i,
    input  xlen_t                       rs2_value_i,
    input  rob_idx_t                    dest_idx_i,

    // Execution unit side
    input  logic                        eu_ready_i,
    input  logic                        eu_valid_i,
    input  logic [$clog2(RS_DEPTH)-1:0] eu_entry_idx_i,
    input  xlen_t                       eu_result_i,
    input  except_e                     eu_except_i,
    output logic                        eu_valid_o,
    output eu_op_e                      eu_ctl_o,
    output xlen_t                       eu_rs1_o,
    output xlen_t                       eu_rs2_o,
    output logic [$clog2(RS_DEPTH)-1:0] eu_entry_idx_o,

    // Common data bus
    input  logic                        cdb_ready_i,
    input  logic                        cdb_valid_i,
    input  rob_idx_t                    cdb_idx_i,
    input  xlen_t                       cdb_data_i,
    input  logic                        cdb_except_raised_i,
    output logic                        cdb_valid_o,
    output rob_idx_t                    cdb_idx_o,
    output xlen_t                       cdb_data_o,
    output logic                        cdb_except_raised_o,
    output except_e                     cdb_except_o
);

    localparam int IDX_W = $clog2(RS_DEPTH);
    typedef logic [IDX_W-1:0] rs_idx_t;

    // Entry status flags, one bit per entry
    logic [RS_DEPTH-1:0] valid_q, busy_q, rs1_rdy_q, rs2_rdy_q, res_rdy_q, exc_raised_q;

    // Entry payload
    eu_op_e   op_q      [RS_DEPTH];
    rob_idx_t rs1_tag_q [RS_DEPTH];
    rob_idx_t rs2_tag_q [RS_DEPTH];
    rob_idx_t dest_q    [RS_DEPTH];
    xlen_t    rs1_val_q [RS_DEPTH];
    xlen_t    rs2_val_q [RS_DEPTH];
    xlen_t    res_val_q [RS_DEPTH];
    except_e  exc_q     [RS_DEPTH];

    // Selector outputs
    rs_idx_t free_idx, ex_idx, cdb_sel;
    logic    free_found, ex_found, cdb_found;

    logic [RS_DEPTH-1:0] ops_rdy, rs1_wake, rs2_wake;
    logic                cdb_hit, ins_rs1_hit, ins_rs2_hit;
    logic                do_insert, do_issue, do_pop;

    // Broadcasts flagged with an exception wake nothing
    assign cdb_hit = cdb_valid_i && !cdb_except_raised_i;
    assign ops_rdy = rs1_rdy_q & rs2_rdy_q;

    // Tag match against waiting operands
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs1_wake[i] = valid_q[i] && !rs1_rdy_q[i] && cdb_hit && (rs1_tag_q[i] == cdb_idx_i);
            rs2_wake[i] = valid_q[i] && !rs2_rdy_q[i] && cdb_hit && (rs2_tag_q[i] == cdb_idx_i);
        end
    end

    // Operand produced in the same cycle as its consumer is issued
    assign ins_rs1_hit = !rs1_ready_i && cdb_hit && (rs1_idx_i == cdb_idx_i);
    assign ins_rs2_hit = !rs2_ready_i && cdb_hit && (rs2_idx_i == cdb_idx_i);

    // Handshakes
    assign arbiter_ready_o = free_found;
    assign eu_valid_o      = ex_found;
    assign cdb_valid_o     = cdb_found;
    assign do_insert       = arbiter_valid_i && free_found;
    assign do_issue        = ex_found && eu_ready_i;
    assign do_pop          = cdb_found && cdb_ready_i;

    // First free slot
    prio_enc #(.N(RS_DEPTH)) i_free_sel (
        .lines_i (~valid_q),
        .enc_o   (free_idx),
        .valid_o (free_found)
    );

    // Waiting entry with both operands in hand
    prio_enc #(.N(RS_DEPTH)) i_ex_sel (
        .lines_i (valid_q & ~busy_q & ~res_rdy_q & ops_rdy),
        .enc_o   (ex_idx),
        .valid_o (ex_found)
    );

    // Finished entry waiting for the bus
    prio_enc #(.N(RS_DEPTH)) i_cdb_sel (
        .lines_i (valid_q & res_rdy_q),
        .enc_o   (cdb_sel),
        .valid_o (cdb_found)
    );

    // Status flags, flush drops every entry
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= '0;
            busy_q       <= '0;
            rs1_rdy_q    <= '0;
            rs2_rdy_q    <= '0;
            res_rdy_q    <= '0;
            exc_raised_q <= '0;
        end else if (flush_i) begin
            valid_q      <= '0;
            busy_q       <= '0;
            rs1_rdy_q    <= '0;
            rs2_rdy_q    <= '0;
            res_rdy_q    <= '0;
            exc_raised_q <= '0;
        end else begin
            // Write port 1, new instruction
            if (do_insert) begin
                valid_q[free_idx]      <= 1'b1;
                busy_q[free_idx]       <= 1'b0;
                rs1_rdy_q[free_idx]    <= rs1_ready_i || ins_rs1_hit;
                rs2_rdy_q[free_idx]    <= rs2_ready_i || ins_rs2_hit;
                res_rdy_q[free_idx]    <= 1'b0;
                exc_raised_q[free_idx] <= 1'b0;
            end
            // Keep a dispatched entry from being picked again
            if (do_issue) begin
                busy_q[ex_idx] <= 1'b1;
            end
            if (do_pop) begin
                valid_q[cdb_sel]   <= 1'b0;
                busy_q[cdb_sel]    <= 1'b0;
                res_rdy_q[cdb_sel] <= 1'b0;
            end
            // Write port 2, result from the EU
            if (eu_valid_i) begin
                res_rdy_q[eu_entry_idx_i]    <= 1'b1;
                exc_raised_q[eu_entry_idx_i] <= (eu_except_i != EXC_NONE);
            end
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (rs1_wake[i]) rs1_rdy_q[i] <= 1'b1;
                if (rs2_wake[i]) rs2_rdy_q[i] <= 1'b1;
            end
        end
    end

    // Payload fields, only meaningful under the flags above
    always_ff @(posedge clk_i) begin
        if (do_insert) begin
            op_q[free_idx]      <= eu_ctl_i;
            rs1_tag_q[free_idx] <= rs1_idx_i;
            rs2_tag_q[free_idx] <= rs2_idx_i;
            dest_q[free_idx]    <= dest_idx_i;
            rs1_val_q[free_idx] <= ins_rs1_hit ? cdb_data_i : rs1_value_i;
            rs2_val_q[free_idx] <= ins_rs2_hit ? cdb_data_i : rs2_value_i;
        end
        if (eu_valid_i) begin
            res_val_q[eu_entry_idx_i] <= eu_result_i;
            exc_q[eu_entry_idx_i]     <= eu_except_i;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs1_wake[i]) rs1_val_q[i] <= cdb_data_i;
            if (rs2_wake[i]) rs2_val_q[i] <= cdb_data_i;
        end
    end

    // Read port 1, operands to the EU
    assign eu_ctl_o       = op_q[ex_idx];
    assign eu_rs1_o       = rs1_val_q[ex_idx];
    assign eu_rs2_o       = rs2_val_q[ex_idx];
    assign eu_entry_idx_o = ex_idx;

    // Read port 2, result to the CDB
    assign cdb_idx_o           = dest_q[cdb_sel];
    assign cdb_data_o          = res_val_q[cdb_sel];
    assign cdb_except_raised_o = exc_raised_q[cdb_sel];
    assign cdb_except_o        = exc_q[cdb_sel];

    // A result can only exist once both operands were captured
    a_res_after_ops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_q & res_rdy_q & ~ops_rdy) == '0)
        else $error("generic_rs: result ready with an operand missing");

    // The EU only returns work it was handed
    a_wb_to_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        eu_valid_i |-> (valid_q[eu_entry_idx_i] && busy_q[eu_entry_idx_i]))
        else $error("generic_rs: write-back to idle entry %0d", eu_entry_idx_i);

endmodule

`default_nettype wire

/* source/int_eu.sv */
// Integer execution unit: one-cycle add, sub, xor and an iterative shift-left
`timescale 1ns/1ns
`default_nettype none

module int_eu
    import core_cfg_pkg::*, expipe_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Request from the station
    input  logic                        valid_i,
    output logic                        ready_o,
    input  eu_op_e                      op_i,
    input  xlen_t                       rs1_i,
    input  xlen_t                       rs2_i,
    input  logic [$clog2(RS_DEPTH)-1:0] entry_idx_i,

    // Result pulse back to the station
    output logic                        valid_o,
    output logic [$clog2(RS_DEPTH)-1:0] entry_idx_o,
    output xlen_t                       result_o,
    output except_e                     except_o
);

    localparam int SHW = $clog2(XLEN);

    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_DONE} eu_state_e;

    eu_state_e      state_q;
    logic           valid_q, accept, bad_shamt, start_shift;
    logic [SHW-1:0] cnt_q;
    xlen_t          acc_q, alu_res;
    except_e        alu_exc;

    // No new work during a shift or while a result is on the way out
    assign ready_o     = (state_q == ST_IDLE) && !valid_q;
    assign accept      = valid_i && ready_o;
    assign bad_shamt   = (rs2_i >= XLEN);
    assign start_shift = (op_i == OP_SLL) && !bad_shamt && (rs2_i[SHW-1:0] != '0);
    assign valid_o     = valid_q;

    // Single-cycle results, overflow still returns the wrapped value
    always_comb begin
        alu_exc = EXC_NONE;
        case (op_i)
            OP_ADD: begin
                alu_res = rs1_i + rs2_i;
                if (rs1_i[XLEN-1] == rs2_i[XLEN-1] && alu_res[XLEN-1] != rs1_i[XLEN-1])
                    alu_exc = EXC_OVERFLOW;
            end
            OP_SUB: begin
                alu_res = rs1_i - rs2_i;
                if (rs1_i[XLEN-1] != rs2_i[XLEN-1] && alu_res[XLEN-1] != rs1_i[XLEN-1])
                    alu_exc = EXC_OVERFLOW;
            end
            OP_XOR: alu_res = rs1_i ^ rs2_i;
            // Zero or illegal shift amount, finished at once
            default: begin
                alu_res = bad_shamt ? '0 : rs1_i;
                alu_exc = bad_shamt ? EXC_BAD_SHAMT : EXC_NONE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // Abort anything in flight
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept && start_shift) state_q <= ST_SHIFT;
                    else if (accept) valid_q <= 1'b1;
                end
                ST_SHIFT: if (cnt_q == SHW'(1)) state_q <= ST_DONE;
                default: begin
                    state_q <= ST_IDLE;
                    valid_q <= 1'b1;
                end
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_idx_o <= entry_idx_i;
            acc_q       <= rs1_i;
            cnt_q       <= rs2_i[SHW-1:0];
            result_o    <= alu_res;
            except_o    <= alu_exc;
        end else if (state_q == ST_SHIFT) begin
            // One bit per cycle
            acc_q <= acc_q << 1;
            cnt_q <= cnt_q - SHW'(1);
        end else if (state_q == ST_DONE) begin
            result_o <= acc_q;
            except_o <= EXC_NONE;
        end
    end

    // Results are single pulses
    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |=> !valid_o)
        else $error("int_eu: result valid held for two cycles");

endmodule

`default_nettype wire

/* source/prio_enc.sv */
// Lowest-index-first priority encoder with a found flag
`timescale 1ns/1ns
`default_nettype none

module prio_enc #(
    parameter int N = 4
) (
    input  logic [N-1:0]         lines_i,
    output logic [$clog2(N)-1:0] enc_o,
    output logic                 valid_o
);

    localparam int W = $clog2(N);

    // Scan from the top down so the lowest set line wins
    always_comb begin
        enc_o   = '0;
        valid_o = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o   = i[W-1:0];
                valid_o = 1'b1;
            end
        end
    end

    // Encoded index must select a request line that is really set
    always_comb begin
        if (valid_o) begin
            assert (lines_i[enc_o])
                else $error("prio_enc: index %0d is not a set line", enc_o);
        end
    end

endmodule

`default_nettype wire

/* source/rs_subsys_top.sv */
// Integer issue path top level: reservation station feeding the integer execution unit
`timescale 1ns/1ns
`default_nettype none

module rs_subsys_top
    import core_cfg_pkg::*, expipe_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,

    // Issue
    input  logic     arbiter_valid_i,
    output logic     arbiter_ready_o,
    input  eu_op_e   eu_ctl_i,
    input  logic     rs1_ready_i,
    input  rob_idx_t rs1_idx_i,
    input  xlen_t    rs1_value_i,
    input  logic     rs2_ready_i,
    input  rob_idx_t rs2_idx_i,
    input  xlen_t    rs2_value_i,
    input  rob_idx_t dest_idx_i,

    // Incoming CDB broadcast
    input  logic     cdb_valid_i,
    input  rob_idx_t cdb_idx_i,
    input  xlen_t    cdb_data_i,
    input  logic     cdb_except_raised_i,

    // Outgoing CDB result
    input  logic     cdb_ready_i,
    output logic     cdb_valid_o,
    output rob_idx_t cdb_idx_o,
    output xlen_t    cdb_data_o,
    output logic     cdb_except_raised_o,
    output except_e  cdb_except_o
);

    // Station to EU
    logic                        disp_valid, disp_ready;
    eu_op_e                      disp_op;
    xlen_t                       disp_rs1, disp_rs2;
    logic [$clog2(RS_DEPTH)-1:0] disp_idx;

    // EU back to station
    logic                        wb_valid;
    logic [$clog2(RS_DEPTH)-1:0] wb_idx;
    xlen_t                       wb_result;
    except_e                     wb_except;

    generic_rs #(.RS_DEPTH(RS_DEPTH)) i_rs (
        .clk_i, .rst_n_i, .flush_i,
        .arbiter_valid_i, .arbiter_ready_o, .eu_ctl_i,
        .rs1_ready_i, .rs1_idx_i, .rs1_value_i,
        .rs2_ready_i, .rs2_idx_i, .rs2_value_i, .dest_idx_i,
        .eu_ready_i          (disp_ready),
        .eu_valid_i          (wb_valid),
        .eu_entry_idx_i      (wb_idx),
        .eu_result_i         (wb_result),
        .eu_except_i         (wb_except),
        .eu_valid_o          (disp_valid),
        .eu_ctl_o            (disp_op),
        .eu_rs1_o            (disp_rs1),
        .eu_rs2_o            (disp_rs2),
        .eu_entry_idx_o      (disp_idx),
        .cdb_ready_i, .cdb_valid_i, .cdb_idx_i, .cdb_data_i, .cdb_except_raised_i,
        .cdb_valid_o, .cdb_idx_o, .cdb_data_o, .cdb_except_raised_o, .cdb_except_o
    );

    int_eu #(.RS_DEPTH(RS_DEPTH)) i_eu (
        .clk_i, .rst_n_i, .flush_i,
        .valid_i     (disp_valid),
        .ready_o     (disp_ready),
        .op_i        (disp_op),
        .rs1_i       (disp_rs1),
        .rs2_i       (disp_rs2),
        .entry_idx_i (disp_idx),
        .valid_o     (wb_valid),
        .entry_idx_o (wb_idx),
        .result_o    (wb_result),
        .except_o    (wb_except)
    );

endmodule

`default_nettype wire

/* verification/rs_subsys_tests.txt */
# I op rs1_rdy rs1_tag rs1_val rs2_rdy rs2_tag rs2_val dest (hex, op 0 add 1 sub 2 xor 3 sll)
# B tag data exc | F flush | W drain | Q cycles | H hold | R release | C ready | U wait ready
I 0 1 0 00000005 1 0 00000007 1
I 1 1 0 00000010 1 0 00000003 2
I 2 1 0 0f0f0f0f 1 0 ffff0000 3
I 3 1 0 00000001 1 0 00000004 4
W
# Operands woken by broadcast
I 0 0 5 00000000 1 0 00000100 6
I 1 1 0 00000050 0 7 00000000 8
B 7 00000020 0
B 5 00000011 0
W
# Overflow and illegal shift amount
I 0 1 0 7fffffff 1 0 00000001 9
I 1 1 0 80000000 1 0 00000001 a
I 3 1 0 00000001 1 0 00000020 b
W
# Faulting broadcast must not wake the consumer
I 2 0 c 00000000 1 0 000000ff d
B c 12345678 1
Q 14
B c 0000aaaa 0
W
# Full station under held back-pressure
H
I 0 1 0 00000001 1 0 00000001 1
I 0 1 0 00000002 1 0 00000002 2
I 0 1 0 00000003 1 0 00000003 3
I 0 1 0 00000004 1 0 00000004 4
Q 4
C 0
R
U
W
# Random back-pressure stream
I 2 1 0 12345678 1 0 87654321 0
I 3 1 0 0000000f 1 0 00000008 1
I 0 1 0 fffffffe 1 0 00000003 2
I 1 1 0 00000000 1 0 00000001 3
I 3 1 0 00000001 1 0 00000000 4
I 0 1 0 80000000 1 0 80000000 5
W
# Flush drops work in flight
I 3 1 0 00000003 1 0 0000001f 5
I 0 0 9 00000000 1 0 00000001 6
F
Q 28
I 1 1 0 00000064 1 0 00000001 7
I 3 1 0 00000003 1 0 00000005 8
W

/* verification/tb_rs_subsys.sv */
// Testbench for the integer issue path: file driven issue and CDB traffic, scoreboard checks
`timescale 1ns/1ns
`default_nettype none

module tb_rs_subsys
    import core_cfg_pkg::*, expipe_pkg::*;
();

    localparam int TMO  = 500;
    localparam int NTAG = 2 ** ROB_IDX_LEN;

    logic     clk_i, rst_n_i, flush_i;
    logic     arbiter_valid_i, arbiter_ready_o;
    eu_op_e   eu_ctl_i;
    logic     rs1_ready_i, rs2_ready_i;
    rob_idx_t rs1_idx_i, rs2_idx_i, dest_idx_i, cdb_idx_i, cdb_idx_o;
    xlen_t    rs1_value_i, rs2_value_i, cdb_data_i, cdb_data_o;
    logic     cdb_valid_i, cdb_except_raised_i, cdb_ready_i;
    logic     cdb_valid_o, cdb_except_raised_o;
    except_e  cdb_except_o;

    // Scoreboard, indexed by destination tag
    logic     exp_valid  [NTAG];
    xlen_t    exp_data   [NTAG];
    except_e  exp_exc    [NTAG];
    // Instructions still waiting for a broadcast operand
    logic     pend       [NTAG];
    eu_op_e   pend_op    [NTAG];
    logic     pend_r1ok  [NTAG];
    logic     pend_r2ok  [NTAG];
    rob_idx_t pend_r1tag [NTAG];
    rob_idx_t pend_r2tag [NTAG];
    xlen_t    pend_r1val [NTAG];
    xlen_t    pend_r2val [NTAG];

    // Fields of the current command line
    xlen_t    fld [8];
    int       outstanding, popped, popped_at_hold;
    logic     hold_cdb;

    rs_subsys_top #(.RS_DEPTH(4)) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                   $time, what, got, exp));
        end
    endtask

    // Reference result, overflow taken from a sign-extended 33-bit sum
    function automatic void model_op(input eu_op_e op, input xlen_t a, input xlen_t b,
                                     output xlen_t res, output except_e exc);
        logic [XLEN:0] wide;
        exc  = EXC_NONE;
        wide = '0;
        res  = '0;
        case (op)
            OP_ADD: wide = {a[XLEN-1], a} + {b[XLEN-1], b};
            OP_SUB: wide = {a[XLEN-1], a} - {b[XLEN-1], b};
            OP_XOR: res = a ^ b;
            default: begin
                if (b >= XLEN) exc = EXC_BAD_SHAMT;
                else res = a << b[$clog2(XLEN)-1:0];
            end
        endcase
        if (op == OP_ADD || op == OP_SUB) begin
            res = wide[XLEN-1:0];
            if (wide[XLEN] != wide[XLEN-1]) exc = EXC_OVERFLOW;
        end
    endfunction

    task automatic store_result(input rob_idx_t tag, input eu_op_e op,
                                input xlen_t a, input xlen_t b);
        xlen_t   res;
        except_e exc;
        model_op(op, a, b, res, exc);
        exp_valid[tag] = 1'b1;
        exp_data[tag]  = res;
        exp_exc[tag]   = exc;
        pend[tag]      = 1'b0;
    endtask

    // Rising edge is the drive point, CDB ready is randomized here
    task automatic next_edge();
        @(posedge clk_i);
        if (!rst_n_i || hold_cdb) cdb_ready_i <= 1'b0;
        else cdb_ready_i <= ($urandom % 4) != 0;
    endtask

    // Falling edge, outputs are stable; a handshake seen here completes at the next edge
    task automatic settle();
        rob_idx_t tag;
        @(negedge clk_i);
        tag = cdb_idx_o;
        if (rst_n_i && !flush_i && cdb_valid_o && cdb_ready_i) begin
            check($sformatf("result expected for tag %0d", tag), 32'(exp_valid[tag]), 32'd1);
            // Data of an illegal shift is undefined
            if (exp_exc[tag] != EXC_BAD_SHAMT) check("cdb_data_o", cdb_data_o, exp_data[tag]);
            check("cdb_except_raised_o", 32'(cdb_except_raised_o),
                  32'(exp_exc[tag] != EXC_NONE));
            check("cdb_except_o", 32'(cdb_except_o), 32'(exp_exc[tag]));
            exp_valid[tag] = 1'b0;
            outstanding--;
            popped++;
        end
    endtask

    task automatic issue_instr();
        int       t;
        eu_op_e   op;
        rob_idx_t tag;
        op  = eu_op_e'(fld[0][1:0]);
        tag = fld[7][ROB_IDX_LEN-1:0];
        next_edge();
        arbiter_valid_i <= 1'b1;
        eu_ctl_i        <= op;
        rs1_ready_i     <= fld[1][0];
        rs1_idx_i       <= fld[2][ROB_IDX_LEN-1:0];
        rs1_value_i     <= fld[3];
        rs2_ready_i     <= fld[4][0];
        rs2_idx_i       <= fld[5][ROB_IDX_LEN-1:0];
        rs2_value_i     <= fld[6];
        dest_idx_i      <= tag;
        settle();
        t = 0;
        // Data held until the station has a free entry
        while (!arbiter_ready_o) begin
            t++;
            if (t > TMO) report_error("Timeout: the station never accepted an instruction");
            next_edge();
            settle();
        end
        next_edge();
        arbiter_valid_i <= 1'b0;
        outstanding++;
        if (fld[1][0] && fld[4][0]) begin
            store_result(tag, op, fld[3], fld[6]);
        end else begin
            pend[tag]       = 1'b1;
            pend_op[tag]    = op;
            pend_r1ok[tag]  = fld[1][0];
            pend_r1tag[tag] = fld[2][ROB_IDX_LEN-1:0];
            pend_r1val[tag] = fld[3];
            pend_r2ok[tag]  = fld[4][0];
            pend_r2tag[tag] = fld[5][ROB_IDX_LEN-1:0];
            pend_r2val[tag] = fld[6];
        end
        settle();
    endtask

    task automatic broadcast();
        rob_idx_t tag;
        tag = fld[0][ROB_IDX_LEN-1:0];
        next_edge();
        cdb_valid_i         <= 1'b1;
        cdb_idx_i           <= tag;
        cdb_data_i          <= fld[1];
        cdb_except_raised_i <= fld[2][0];
        settle();
        next_edge();
        cdb_valid_i <= 1'b0;
        // A faulting producer wakes nobody
        if (!fld[2][0]) begin
            for (int d = 0; d < NTAG; d++) begin
                if (pend[d] && !pend_r1ok[d] && pend_r1tag[d] == tag) begin
                    pend_r1ok[d]  = 1'b1;
                    pend_r1val[d] = fld[1];
                end
                if (pend[d] && !pend_r2ok[d] && pend_r2tag[d] == tag) begin
                    pend_r2ok[d]  = 1'b1;
                    pend_r2val[d] = fld[1];
                end
                if (pend[d] && pend_r1ok[d] && pend_r2ok[d]) begin
                    store_result(rob_idx_t'(d), pend_op[d], pend_r1val[d], pend_r2val[d]);
                end
            end
        end
        settle();
    endtask

    task automatic flush_all();
        next_edge();
        flush_i <= 1'b1;
        for (int d = 0; d < NTAG; d++) begin
            exp_valid[d] = 1'b0;
            pend[d]      = 1'b0;
        end
        outstanding = 0;
        settle();
        next_edge();
        flush_i <= 1'b0;
        settle();
    endtask

    // Generic bounded wait on a condition code
    task automatic wait_for(input bit want_drain, input string what);
        int t;
        t = 0;
        while (want_drain ? (outstanding != 0) : !arbiter_ready_o) begin
            t++;
            if (t > TMO) report_error({"Timeout: ", what});
            next_edge();
            settle();
        end
    endtask

    initial begin
        int         fd;
        int         n;
        string      line;
        logic [7:0] cmd;
        void'($urandom(81210));
        rst_n_i             = 1'b0;
        flush_i             = 1'b0;
        arbiter_valid_i     = 1'b0;
        eu_ctl_i            = OP_ADD;
        rs1_ready_i         = 1'b0;
        rs1_idx_i           = '0;
        rs1_value_i         = '0;
        rs2_ready_i         = 1'b0;
        rs2_idx_i           = '0;
        rs2_value_i         = '0;
        dest_idx_i          = '0;
        cdb_valid_i         = 1'b0;
        cdb_idx_i           = '0;
        cdb_data_i          = '0;
        cdb_except_raised_i = 1'b0;
        cdb_ready_i         = 1'b0;
        hold_cdb            = 1'b0;
        outstanding         = 0;
        popped              = 0;
        popped_at_hold      = 0;
        for (int d = 0; d < NTAG; d++) begin
            exp_valid[d] = 1'b0;
            exp_exc[d]   = EXC_NONE;
            pend[d]      = 1'b0;
        end
        repeat (5) begin
            next_edge();
            settle();
        end
        next_edge();
        rst_n_i <= 1'b1;
        settle();
        // Idle state after reset
        check("arbiter_ready_o after reset", 32'(arbiter_ready_o), 32'd1);
        check("cdb_valid_o after reset", 32'(cdb_valid_o), 32'd0);
        fd = $fopen("verification/rs_subsys_tests.txt", "r");
        if (fd == 0) report_error("Could not open verification/rs_subsys_tests.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", cmd,
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
                case (cmd)
                    "I": issue_instr();
                    "B": broadcast();
                    "F": flush_all();
                    "W": wait_for(1'b1, "results still missing");
                    "Q": repeat (fld[0]) begin
                        next_edge();
                        settle();
                    end
                    "H": begin
                        hold_cdb       = 1'b1;
                        popped_at_hold = popped;
                    end
                    "R": hold_cdb = 1'b0;
                    "C": check("arbiter_ready_o", 32'(arbiter_ready_o), 32'(fld[0][0]));
                    "U": begin
                        wait_for(1'b0, "the station never freed an entry");
                        check("result drained before entry freed",
                              32'(popped > popped_at_hold), 32'd1);
                    end
                    "#", "\n": ;
                    default: report_error({"Unknown command in test file: ", line});
                endcase
            end
        end
        $fclose(fd);
        if (outstanding == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_error("Results still outstanding at the end of the test file");
        end
    end

endmodule

`default_nettype wire
